// ==== src/muldiv_pkg.sv ====
// multiply/divide unit shared types
package muldiv_pkg;

  typedef logic [63:0] xlen_t;  // operand and result word
  typedef logic [3:0]  tag_t;   // identifies a result on the writeback bus

  // ======================================================================
  // operation encoding
  // ======================================================================
  typedef enum logic [3:0] {
    MD_MUL    = 4'd0,
    MD_MULH   = 4'd1,
    MD_MULHSU = 4'd2,
    MD_MULHU  = 4'd3,
    MD_MULW   = 4'd4,
    MD_DIV    = 4'd5,
    MD_DIVU   = 4'd6,
    MD_DIVW   = 4'd7,
    MD_DIVUW  = 4'd8,
    MD_REM    = 4'd9,
    MD_REMU   = 4'd10,
    MD_REMW   = 4'd11,
    MD_REMUW  = 4'd12
  } md_op_e;

  typedef struct packed {
    md_op_e op;
    xlen_t  rs1;
    xlen_t  rs2;
    tag_t   tag;
  } md_req_t;

  typedef struct packed {
    xlen_t data;
    tag_t  tag;
  } md_wb_t;

  // ======================================================================
  // op class helpers
  // ======================================================================
  function automatic logic md_is_div(md_op_e op);
    return (op >= MD_DIV) && (op <= MD_REMUW);
  endfunction

  function automatic logic md_is_word(md_op_e op);
    return (op == MD_MULW) || (op == MD_DIVW) || (op == MD_DIVUW) ||
           (op == MD_REMW) || (op == MD_REMUW);
  endfunction

  function automatic logic md_is_signed_div(md_op_e op);
    return (op == MD_DIV) || (op == MD_DIVW) || (op == MD_REM) || (op == MD_REMW);
  endfunction

  function automatic logic md_is_rem(md_op_e op);
    return (op == MD_REM) || (op == MD_REMU) || (op == MD_REMW) || (op == MD_REMUW);
  endfunction

endpackage

// ==== src/div_operand_prep.sv ====
// divider operand preparation
`timescale 1ns/1ps

module div_operand_prep (
  input  muldiv_pkg::md_op_e op_i,
  input  muldiv_pkg::xlen_t  rs1_i,
  input  muldiv_pkg::xlen_t  rs2_i,
  output muldiv_pkg::xlen_t  dividend_abs_o,
  output muldiv_pkg::xlen_t  divisor_abs_o,
  output logic               quot_neg_o,
  output logic               rem_neg_o,
  output logic               exc_o,
  output muldiv_pkg::xlen_t  exc_result_o
);

  logic              is_word;
  logic              is_signed;
  logic              is_rem;
  muldiv_pkg::xlen_t a_ext, b_ext;
  muldiv_pkg::xlen_t a_abs, b_abs;
  muldiv_pkg::xlen_t a_sext;  // dividend as rd would see it
  logic              a_neg, b_neg;
  logic              div_zero, div_ovf;

  assign is_word   = muldiv_pkg::md_is_word(op_i);
  assign is_signed = muldiv_pkg::md_is_signed_div(op_i);
  assign is_rem    = muldiv_pkg::md_is_rem(op_i);

  // ======================================================================
  // extension and absolute values
  // ======================================================================
  always_comb begin
    if (is_word) begin
      a_ext = is_signed ? {{32{rs1_i[31]}}, rs1_i[31:0]} : {32'b0, rs1_i[31:0]};
      b_ext = is_signed ? {{32{rs2_i[31]}}, rs2_i[31:0]} : {32'b0, rs2_i[31:0]};
    end else begin
      a_ext = rs1_i;
      b_ext = rs2_i;
    end
  end

  assign a_neg  = is_signed & a_ext[63];
  assign b_neg  = is_signed & b_ext[63];
  assign a_abs  = a_neg ? -a_ext : a_ext;
  assign b_abs  = b_neg ? -b_ext : b_ext;
  assign a_sext = is_word ? {{32{rs1_i[31]}}, rs1_i[31:0]} : rs1_i;

  // word dividend sits in the upper half, so 32 shifts finish it
  assign dividend_abs_o = is_word ? {a_abs[31:0], 32'b0} : a_abs;
  assign divisor_abs_o  = is_word ? {32'b0, b_abs[31:0]} : b_abs;
  assign quot_neg_o     = a_neg ^ b_neg;
  assign rem_neg_o      = a_neg;  // remainder follows the dividend

  // ======================================================================
  // divide-by-zero and signed overflow
  // ======================================================================
  assign div_zero = is_word ? (rs2_i[31:0] == 32'b0) : (rs2_i == 64'b0);
  assign div_ovf  = is_signed & (is_word ?
                    (rs1_i[31:0] == 32'h8000_0000) && (&rs2_i[31:0]) :
                    (rs1_i == 64'h8000_0000_0000_0000) && (&rs2_i));

  assign exc_o = div_zero | div_ovf;

  always_comb begin
    if (div_zero) begin
      exc_result_o = is_rem ? a_sext : '1;  // quotient all ones
    end else begin
      exc_result_o = is_rem ? '0 : a_sext;  // overflow
    end
  end

endmodule

// ==== src/iter_divider.sv ====
// restoring iterative divider
`timescale 1ns/1ps

module iter_divider #(
  parameter int TAG_W = 4
) (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                start_i,
  input  muldiv_pkg::md_req_t req_i,
  input  logic                grant_i,
  output logic                busy_o,
  output logic                done_o,
  output muldiv_pkg::md_wb_t  result_o
);

  typedef enum logic [1:0] {
    DIV_IDLE,
    DIV_ITER,
    DIV_DONE
  } div_state_e;

  div_state_e        state_q;
  logic [6:0]        cnt_q;         // iterations left
  logic [127:0]      rq_q;          // remainder:quotient
  muldiv_pkg::xlen_t divisor_q;
  logic              quot_neg_q;
  logic              rem_neg_q;
  logic              is_rem_q;
  logic              is_word_q;
  logic              exc_q;
  logic [TAG_W-1:0]  tag_q;

  muldiv_pkg::xlen_t dividend_abs, divisor_abs;
  muldiv_pkg::xlen_t exc_result;
  logic              quot_neg, rem_neg, exc;

  logic [64:0]       diff;
  logic [127:0]      rq_next;
  muldiv_pkg::xlen_t mag, signed_res;

  div_operand_prep u_prep (
    .op_i           (req_i.op),
    .rs1_i          (req_i.rs1),
    .rs2_i          (req_i.rs2),
    .dividend_abs_o (dividend_abs),
    .divisor_abs_o  (divisor_abs),
    .quot_neg_o     (quot_neg),
    .rem_neg_o      (rem_neg),
    .exc_o          (exc),
    .exc_result_o   (exc_result)
  );

  // ======================================================================
  // one restoring step
  // ======================================================================
  assign diff = rq_q[127:63] - {1'b0, divisor_q};  // trial subtract of shifted rem

  always_comb begin
    if (diff[64]) begin
      rq_next = {rq_q[126:0], 1'b0};             // restore, quotient bit 0
    end else begin
      rq_next = {diff[63:0], rq_q[62:0], 1'b1};
    end
  end

  // ======================================================================
  // control
  // ======================================================================
  always_ff @(posedge clk) begin
    if (rst_n) begin
      state_q <= DIV_IDLE;
      cnt_q   <= '0;
    end else begin
      case (state_q)
        DIV_IDLE: begin
          if (start_i) begin
            // exceptions skip the iterations
            state_q <= exc ? DIV_DONE : DIV_ITER;
            cnt_q   <= muldiv_pkg::md_is_word(req_i.op) ? 7'd32 : 7'd64;
          end
        end
        DIV_ITER: begin
          cnt_q <= cnt_q - 7'd1;
          if (cnt_q == 7'd1) begin
            state_q <= DIV_DONE;
          end
        end
        DIV_DONE: begin
          if (grant_i) begin
            state_q <= DIV_IDLE;
          end
        end
        default: state_q <= DIV_IDLE;
      endcase
    end
  end

  // datapath
  always_ff @(posedge clk) begin
    if (state_q == DIV_IDLE && start_i) begin
      rq_q       <= {64'b0, (exc ? exc_result : dividend_abs)};
      divisor_q  <= divisor_abs;
      quot_neg_q <= quot_neg;
      rem_neg_q  <= rem_neg;
      is_rem_q   <= muldiv_pkg::md_is_rem(req_i.op);
      is_word_q  <= muldiv_pkg::md_is_word(req_i.op);
      exc_q      <= exc;
      tag_q      <= TAG_W'(req_i.tag);
    end else if (state_q == DIV_ITER) begin
      rq_q <= rq_next;
    end
  end

  // ======================================================================
  // result
  // ======================================================================
  always_comb begin
    mag        = is_rem_q ? rq_q[127:64] : rq_q[63:0];
    signed_res = (is_rem_q ? rem_neg_q : quot_neg_q) ? -mag : mag;
    if (exc_q) begin
      result_o.data = rq_q[63:0];  // already final
    end else if (is_word_q) begin
      result_o.data = {{32{signed_res[31]}}, signed_res[31:0]};
    end else begin
      result_o.data = signed_res;
    end
    result_o.tag = muldiv_pkg::tag_t'(tag_q);
  end

  assign busy_o = (state_q == DIV_IDLE && start_i) || (state_q == DIV_ITER);
  assign done_o = (state_q == DIV_DONE);

endmodule

// ==== src/iter_multiplier.sv ====
// shift-add iterative multiplier
`timescale 1ns/1ps

module iter_multiplier #(
  parameter int TAG_W = 4
) (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                start_i,
  input  muldiv_pkg::md_req_t req_i,
  input  logic                grant_i,
  output logic                busy_o,
  output logic                done_o,
  output muldiv_pkg::md_wb_t  result_o
);

  typedef enum logic [1:0] {
    MUL_IDLE,
    MUL_ITER,
    MUL_DONE
  } mul_state_e;

  mul_state_e        state_q;
  logic [6:0]        cnt_q;
  logic [127:0]      acc_q;     // product accumulator
  logic [127:0]      mcand_q;   // shifts left each step
  muldiv_pkg::xlen_t mplier_q;  // shifts right each step
  logic              neg_q;
  logic              hi_q;
  logic              word_q;
  logic [TAG_W-1:0]  tag_q;

  logic              is_word;
  logic              a_neg, b_neg;
  muldiv_pkg::xlen_t a_abs, b_abs;
  logic [127:0]      prod;

  // ======================================================================
  // operand signs
  // ======================================================================
  assign is_word = muldiv_pkg::md_is_word(req_i.op);
  assign a_neg   = ((req_i.op == muldiv_pkg::MD_MULH) ||
                    (req_i.op == muldiv_pkg::MD_MULHSU)) && req_i.rs1[63];
  assign b_neg   = (req_i.op == muldiv_pkg::MD_MULH) && req_i.rs2[63];  // mulhsu: rs2 unsigned
  assign a_abs   = a_neg ? -req_i.rs1 : req_i.rs1;
  assign b_abs   = b_neg ? -req_i.rs2 : req_i.rs2;

  always_ff @(posedge clk) begin
    if (rst_n) begin
      state_q <= MUL_IDLE;
      cnt_q   <= '0;
    end else begin
      case (state_q)
        MUL_IDLE: if (start_i) begin
          state_q <= MUL_ITER;
          cnt_q   <= is_word ? 7'd32 : 7'd64;
        end
        MUL_ITER: begin
          cnt_q <= cnt_q - 7'd1;
          if (cnt_q == 7'd1) state_q <= MUL_DONE;
        end
        MUL_DONE: if (grant_i) state_q <= MUL_IDLE;
        default: state_q <= MUL_IDLE;
      endcase
    end
  end

  // datapath, low word of the product ignores signs
  always_ff @(posedge clk) begin
    if (state_q == MUL_IDLE && start_i) begin
      acc_q    <= '0;
      mcand_q  <= is_word ? {96'b0, req_i.rs1[31:0]} : {64'b0, a_abs};
      mplier_q <= is_word ? {32'b0, req_i.rs2[31:0]} : b_abs;
      neg_q    <= a_neg ^ b_neg;
      hi_q     <= !is_word && (req_i.op != muldiv_pkg::MD_MUL);
      word_q   <= is_word;
      tag_q    <= TAG_W'(req_i.tag);
    end else if (state_q == MUL_ITER) begin
      if (mplier_q[0]) acc_q <= acc_q + mcand_q;
      mcand_q  <= {mcand_q[126:0], 1'b0};
      mplier_q <= {1'b0, mplier_q[63:1]};
    end
  end

  // ======================================================================
  // result select
  // ======================================================================
  assign prod = neg_q ? (~acc_q + 128'd1) : acc_q;

  always_comb begin
    if (word_q) begin
      result_o.data = {{32{prod[31]}}, prod[31:0]};
    end else if (hi_q) begin
      result_o.data = prod[127:64];
    end else begin
      result_o.data = prod[63:0];
    end
    result_o.tag = muldiv_pkg::tag_t'(tag_q);
  end

  assign busy_o = (state_q == MUL_IDLE && start_i) || (state_q == MUL_ITER);
  assign done_o = (state_q == MUL_DONE);

endmodule

// ==== src/wb_arbiter.sv ====
// writeback bus arbiter
`timescale 1ns/1ps

module wb_arbiter (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               div_done_i,
  input  muldiv_pkg::md_wb_t div_result_i,
  input  logic               mul_done_i,
  input  muldiv_pkg::md_wb_t mul_result_i,
  input  logic               wb_ready_i,
  output logic               div_grant_o,
  output logic               mul_grant_o,
  output logic               wb_valid_o,
  output muldiv_pkg::md_wb_t wb_o
);

  logic ptr_q;       // 1 favours the multiplier
  logic hold_q;      // a result was shown but not taken
  logic hold_mul_q;  // engine shown last cycle
  logic rr_mul;
  logic pick_mul;

  // round-robin choice when both engines wait
  assign rr_mul   = mul_done_i && (!div_done_i || ptr_q);
  // a stalled result stays on the bus until taken
  assign pick_mul = hold_q ? hold_mul_q : rr_mul;

  assign wb_valid_o  = div_done_i | mul_done_i;
  assign wb_o        = pick_mul ? mul_result_i : div_result_i;
  assign mul_grant_o = wb_ready_i && pick_mul;
  assign div_grant_o = wb_ready_i && div_done_i && !pick_mul;

  // ======================================================================
  // pointer and hold state
  // ======================================================================
  always_ff @(posedge clk) begin
    if (rst_n) begin
      ptr_q      <= 1'b0;
      hold_q     <= 1'b0;
      hold_mul_q <= 1'b0;
    end else begin
      if (mul_grant_o) begin
        ptr_q <= 1'b0;  // move past the multiplier
      end else if (div_grant_o) begin
        ptr_q <= 1'b1;
      end
      hold_q     <= wb_valid_o && !wb_ready_i;
      hold_mul_q <= pick_mul;
    end
  end

endmodule

// ==== src/muldiv_unit.sv ====
// multiply/divide unit top level
`timescale 1ns/1ps

module muldiv_unit #(
  parameter int TAG_W = 4
) (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                req_valid_i,
  input  muldiv_pkg::md_req_t req_i,
  output logic                req_ready_o,
  output logic                wb_valid_o,
  output muldiv_pkg::md_wb_t  wb_o,
  input  logic                wb_ready_i
);

  logic               div_sel;
  logic               div_start, mul_start;
  logic               div_busy, div_done, div_grant;
  logic               mul_busy, mul_done, mul_grant;
  muldiv_pkg::md_wb_t div_result, mul_result;

  // ======================================================================
  // request steering
  // ======================================================================
  assign div_sel   = muldiv_pkg::md_is_div(req_i.op);
  assign div_start = req_valid_i && div_sel;
  assign mul_start = req_valid_i && !div_sel;

  // engine must be idle, neither working nor holding a result
  assign req_ready_o = div_sel ? !(div_busy || div_done) : !(mul_busy || mul_done);

  iter_divider #(
    .TAG_W (TAG_W)
  ) u_div (
    .clk      (clk),
    .rst_n    (rst_n),
    .start_i  (div_start),
    .req_i    (req_i),
    .grant_i  (div_grant),
    .busy_o   (div_busy),
    .done_o   (div_done),
    .result_o (div_result)
  );

  iter_multiplier #(
    .TAG_W (TAG_W)
  ) u_mul (
    .clk      (clk),
    .rst_n    (rst_n),
    .start_i  (mul_start),
    .req_i    (req_i),
    .grant_i  (mul_grant),
    .busy_o   (mul_busy),
    .done_o   (mul_done),
    .result_o (mul_result)
  );

  // shared writeback
  wb_arbiter u_arb (
    .clk          (clk),
    .rst_n        (rst_n),
    .div_done_i   (div_done),
    .div_result_i (div_result),
    .mul_done_i   (mul_done),
    .mul_result_i (mul_result),
    .wb_ready_i   (wb_ready_i),
    .div_grant_o  (div_grant),
    .mul_grant_o  (mul_grant),
    .wb_valid_o   (wb_valid_o),
    .wb_o         (wb_o)
  );

endmodule

// ==== test/tb_muldiv_ref.svh ====
// muldiv reference model
`ifndef TB_MULDIV_REF_SVH
`define TB_MULDIV_REF_SVH

  // ======================================================================
  // random source
  // ======================================================================
  function automatic logic [31:0] lfsr_step(logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);  // taps 32,22,2,1
  endfunction

  // one lfsr step per bit
  task automatic get_rand(output muldiv_pkg::xlen_t v);
    v = '0;
    for (int i = 0; i < 64; i++) begin
      lfsr_q = lfsr_step(lfsr_q);
      v = {v[62:0], lfsr_q[0]};
    end
  endtask

  // ======================================================================
  // expected results
  // ======================================================================
  // 65-bit signed math, so min / -1 does not overflow
  function automatic muldiv_pkg::xlen_t div_ref(muldiv_pkg::xlen_t a, muldiv_pkg::xlen_t b,
                                                 bit sgn, bit rem, bit word);
    logic signed [64:0] x, y, q, r;
    muldiv_pkg::xlen_t  res;
    if (word) begin
      x = sgn ? {{33{a[31]}}, a[31:0]} : {33'b0, a[31:0]};
      y = sgn ? {{33{b[31]}}, b[31:0]} : {33'b0, b[31:0]};
    end else begin
      x = sgn ? {a[63], a} : {1'b0, a};
      y = sgn ? {b[63], b} : {1'b0, b};
    end
    if (y == 65'sd0) begin
      q = -65'sd1;
      r = x;
    end else begin
      q = x / y;
      r = x % y;
    end
    res = rem ? r[63:0] : q[63:0];
    if (word) res = {{32{res[31]}}, res[31:0]};
    return res;
  endfunction

  function automatic muldiv_pkg::xlen_t ref_result(muldiv_pkg::md_op_e op,
                                                    muldiv_pkg::xlen_t a, muldiv_pkg::xlen_t b);
    logic [127:0] p;
    p = '0;
    case (op)
      muldiv_pkg::MD_MUL:    p = {64'b0, a} * {64'b0, b};
      muldiv_pkg::MD_MULH:   p = {{64{a[63]}}, a} * {{64{b[63]}}, b};  // mod 2^128 is exact
      muldiv_pkg::MD_MULHSU: p = {{64{a[63]}}, a} * {64'b0, b};
      muldiv_pkg::MD_MULHU:  p = {64'b0, a} * {64'b0, b};
      muldiv_pkg::MD_MULW:   p = {64'b0, a} * {64'b0, b};
      default: ;
    endcase
    case (op)
      muldiv_pkg::MD_MUL:    return p[63:0];
      muldiv_pkg::MD_MULH,
      muldiv_pkg::MD_MULHSU,
      muldiv_pkg::MD_MULHU:  return p[127:64];
      muldiv_pkg::MD_MULW:   return {{32{p[31]}}, p[31:0]};
      muldiv_pkg::MD_DIV:    return div_ref(a, b, 1'b1, 1'b0, 1'b0);
      muldiv_pkg::MD_DIVU:   return div_ref(a, b, 1'b0, 1'b0, 1'b0);
      muldiv_pkg::MD_REM:    return div_ref(a, b, 1'b1, 1'b1, 1'b0);
      muldiv_pkg::MD_REMU:   return div_ref(a, b, 1'b0, 1'b1, 1'b0);
      muldiv_pkg::MD_DIVW:   return div_ref(a, b, 1'b1, 1'b0, 1'b1);
      muldiv_pkg::MD_DIVUW:  return div_ref(a, b, 1'b0, 1'b0, 1'b1);
      muldiv_pkg::MD_REMW:   return div_ref(a, b, 1'b1, 1'b1, 1'b1);
      default:               return div_ref(a, b, 1'b0, 1'b1, 1'b1);
    endcase
  endfunction

  // ======================================================================
  // compare
  // ======================================================================
  task automatic check_value(string name, muldiv_pkg::xlen_t got, muldiv_pkg::xlen_t exp);
    if (got !== exp) begin
      err_cnt++;
      $display("Fail %s: got %h expected %h", name, got, exp);
    end
  endtask

`endif

// ==== test/tb_muldiv_unit.sv ====
// muldiv unit testbench
`timescale 1ns/1ps

module tb_muldiv_unit;

  localparam int N_DIV64 = 24;
  localparam int N_DIVW  = 16;
  localparam int N_EXC   = 12;
  localparam int N_MULR  = 20;
  localparam int N_MULC  = 80;
  localparam int N_BP    = 24;  // 12 div/mul pairs
  localparam int N_REQ   = N_DIV64 + N_DIVW + N_EXC + N_MULR + N_MULC + N_BP;
  localparam int LIMIT   = 80 * N_REQ + 500;

  logic                clk;
  logic                rst_n;
  logic                req_valid_i;
  muldiv_pkg::md_req_t req_i;
  logic                req_ready_o;
  logic                wb_valid_o;
  muldiv_pkg::md_wb_t  wb_o;
  logic                wb_ready_i;

  logic [31:0]       lfsr_q;
  logic [31:0]       bp_lfsr_q;
  int                err_cnt;
  int                miss_cnt;
  int                cycle_cnt;
  bit                bp_mode;
  int                div_xfers, mul_xfers;
  muldiv_pkg::xlen_t exp_tab [16];
  bit                pending [16];
  bit                is_div_tab [16];
  logic [3:0]        next_tag;
  bit                stall_seen;
  muldiv_pkg::md_wb_t held_wb;

  `include "tb_muldiv_ref.svh"

  muldiv_unit #(
    .TAG_W (4)
  ) uut (
    .clk         (clk),
    .rst_n       (rst_n),
    .req_valid_i (req_valid_i),
    .req_i       (req_i),
    .req_ready_o (req_ready_o),
    .wb_valid_o  (wb_valid_o),
    .wb_o        (wb_o),
    .wb_ready_i  (wb_ready_i)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // run limit
  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= LIMIT) begin
      $display("timeout: run did not finish within %0d cycles", LIMIT);
      $display("Test failures found");
      $finish;
    end
  end

  // random stall of the writeback bus
  always @(posedge clk) begin
    bp_lfsr_q  <= lfsr_step(bp_lfsr_q);
    wb_ready_i <= bp_mode ? bp_lfsr_q[0] : 1'b1;
  end

  // ======================================================================
  // scoreboard
  // ======================================================================
  always @(negedge clk) begin
    if (!rst_n) begin
      if (stall_seen && wb_valid_o) begin  // must hold while stalled
        check_value("wb_o.data (stalled)", wb_o.data, held_wb.data);
        check_value("wb_o.tag (stalled)", {60'b0, wb_o.tag}, {60'b0, held_wb.tag});
      end
      if (wb_valid_o && wb_ready_i) begin
        if (!pending[wb_o.tag]) begin
          err_cnt++;
          $display("result for tag %0d arrived without a pending request", wb_o.tag);
        end else begin
          check_value("wb_o.data", wb_o.data, exp_tab[wb_o.tag]);
          pending[wb_o.tag] = 1'b0;
          if (bp_mode) begin
            if (is_div_tab[wb_o.tag]) div_xfers++;
            else mul_xfers++;
          end
        end
      end
      stall_seen = wb_valid_o && !wb_ready_i;
      held_wb    = wb_o;
    end
  end

  task automatic issue(muldiv_pkg::md_op_e op, muldiv_pkg::xlen_t a, muldiv_pkg::xlen_t b);
    muldiv_pkg::md_req_t r;
    while (pending[next_tag]) @(negedge clk);  // tag still in flight
    r.op  = op;
    r.rs1 = a;
    r.rs2 = b;
    r.tag = next_tag;
    exp_tab[next_tag]    = ref_result(op, a, b);
    is_div_tab[next_tag] = (op >= muldiv_pkg::MD_DIV);
    pending[next_tag]    = 1'b1;
    @(posedge clk);
    req_i <= r;
    @(negedge clk);
    while (!req_ready_o) @(negedge clk);
    @(posedge clk);
    req_valid_i <= 1'b1;
    @(posedge clk);
    req_valid_i <= 1'b0;
    next_tag = next_tag + 4'd1;
  endtask

  // any tag still waiting for its result
  function automatic bit any_pending();
    bit found;
    found = 1'b0;
    for (int i = 0; i < 16; i++) begin
      found |= pending[i];
    end
    return found;
  endfunction

  // ======================================================================
  // stimulus
  // ======================================================================
  initial begin
    muldiv_pkg::md_op_e div_ops [4];
    muldiv_pkg::md_op_e w_ops [4];
    muldiv_pkg::md_op_e mul_ops [5];
    muldiv_pkg::md_op_e all_div [8];
    muldiv_pkg::xlen_t  corners [4];
    muldiv_pkg::xlen_t  a, b, s;
    div_ops = '{muldiv_pkg::MD_DIV, muldiv_pkg::MD_DIVU, muldiv_pkg::MD_REM, muldiv_pkg::MD_REMU};
    w_ops   = '{muldiv_pkg::MD_DIVW, muldiv_pkg::MD_DIVUW, muldiv_pkg::MD_REMW,
                muldiv_pkg::MD_REMUW};
    mul_ops = '{muldiv_pkg::MD_MUL, muldiv_pkg::MD_MULH, muldiv_pkg::MD_MULHSU,
                muldiv_pkg::MD_MULHU, muldiv_pkg::MD_MULW};
    for (int i = 0; i < 4; i++) begin
      all_div[i]     = div_ops[i];
      all_div[i + 4] = w_ops[i];
    end
    corners = '{64'd0, 64'd1, 64'hffff_ffff_ffff_ffff, 64'h8000_0000_0000_0000};
    lfsr_q = 32'h12d3;
    bp_lfsr_q = 32'h12d3;
    err_cnt = 0;
    miss_cnt = 0;
    cycle_cnt = 0;
    bp_mode = 1'b0;
    div_xfers = 0;
    mul_xfers = 0;
    next_tag = '0;
    stall_seen = 1'b0;
    held_wb = '0;
    for (int i = 0; i < 16; i++) pending[i] = 1'b0;
    rst_n = 1'b1;
    req_valid_i = 1'b0;
    req_i = '0;
    wb_ready_i = 1'b1;

    repeat (10) @(posedge clk);
    rst_n <= 1'b0;

    // reset state
    @(posedge clk);
    req_i.op <= muldiv_pkg::MD_DIV;
    @(negedge clk);
    check_value("wb_valid_o", {63'b0, wb_valid_o}, 64'd0);
    check_value("req_ready_o (div)", {63'b0, req_ready_o}, 64'd1);
    @(posedge clk);
    req_i.op <= muldiv_pkg::MD_MUL;
    @(negedge clk);
    check_value("req_ready_o (mul)", {63'b0, req_ready_o}, 64'd1);

    for (int i = 0; i < N_DIV64; i++) begin
      get_rand(a);
      get_rand(b);
      get_rand(s);
      b = b >> s[5:0];  // spread divisor sizes
      issue(div_ops[i % 4], a, s[6] ? -b : b);  // divisor of either sign
    end
    for (int i = 0; i < N_DIVW; i++) begin
      get_rand(a);
      get_rand(b);
      get_rand(s);
      issue(w_ops[i % 4], a, b >> s[4:0]);
    end
    // divide by zero, then signed overflow
    for (int i = 0; i < 8; i++) begin
      get_rand(a);
      issue(all_div[i], a, {b[63:32], 32'b0} & ((i < 4) ? 64'd0 : 64'hffff_ffff_0000_0000));
    end
    issue(muldiv_pkg::MD_DIV, 64'h8000_0000_0000_0000, '1);
    issue(muldiv_pkg::MD_REM, 64'h8000_0000_0000_0000, '1);
    issue(muldiv_pkg::MD_DIVW, 64'h1234_5678_8000_0000, 64'h0000_0abc_ffff_ffff);
    issue(muldiv_pkg::MD_REMW, 64'h1234_5678_8000_0000, 64'h0000_0abc_ffff_ffff);

    for (int i = 0; i < N_MULR; i++) begin
      get_rand(a);
      get_rand(b);
      issue(mul_ops[i % 5], a, b);
    end
    for (int k = 0; k < 5; k++)
      for (int i = 0; i < 4; i++)
        for (int j = 0; j < 4; j++)
          issue(mul_ops[k], corners[i], corners[j]);

    // earlier results leave the bus first
    while (any_pending()) @(negedge clk);

    // both engines at once under back-pressure
    bp_mode = 1'b1;
    for (int i = 0; i < N_BP / 2; i++) begin
      get_rand(a);
      get_rand(b);
      issue(all_div[i % 8], a, b >> a[5:0]);
      get_rand(a);
      get_rand(b);
      issue(mul_ops[i % 5], a, b);
    end

    // bounded wait for the last results
    for (int c = 0; c < 400 && any_pending(); c++) begin
      @(negedge clk);
    end
    for (int i = 0; i < 16; i++) begin
      if (pending[i]) begin
        miss_cnt++;
        $display("missing result for tag %0d", i);
      end
    end
    if (div_xfers == 0 || mul_xfers == 0) begin
      err_cnt++;
      $display("back-pressure phase did not see a transfer from both engines");
    end

    $display("errors: %0d mismatches, %0d missing results", err_cnt, miss_cnt);
    if (err_cnt == 0 && miss_cnt == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

// ==== muldiv_unit.f ====
+incdir+test
src/muldiv_pkg.sv
src/div_operand_prep.sv
src/iter_divider.sv
src/iter_multiplier.sv
src/wb_arbiter.sv
src/muldiv_unit.sv
test/tb_muldiv_unit.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the muldiv_unit testbench with Verilator.
set -e

cd "$(dirname "$0")"

verilator --binary --timing -f muldiv_unit.f --top-module tb_muldiv_unit

out=$(./obj_dir/Vtb_muldiv_unit)
echo "$out"

if echo "$out" | grep -q "All tests passed!"; then
  exit 0
else
  exit 1
fi
